/* files.f */
+incdir+tb
verilog/ss_addresses.sv
verilog/bus_connector.sv
verilog/clock.sv
verilog/seconds_counter.sv
verilog/timer_irq.sv
verilog/timer_apb_regs.sv
verilog/system_timer_top.sv
tb/tb_system_timer.sv

/* tb/tb_system_timer_ref.svh */
`ifndef TB_SYSTEM_TIMER_REF_SVH
`define TB_SYSTEM_TIMER_REF_SVH

// Ticks seen after n enabled cycles since a timer reset, first wrap skipped.
function automatic int ticks_after(int n);
  if (n <= 1) begin
    return 0;
  end
  return (n - 1) >> 3;
endfunction

function automatic logic [7:0] timer_ref(int base, int n);
  return 8'(base + ticks_after(n));
endfunction

// Seconds advance one enabled cycle after hz1 falls.
function automatic logic [23:0] seconds_ref(logic [23:0] value, int n);
  return 24'(value + ticks_after(n - 1) / 256);
endfunction

// Flags 32, 8, 2 and 1 Hz. A fall counts when it lands at or after the clear edge nc.
function automatic logic [3:0] flags_ref(int n, int nc);
  int          pos[4] = '{2, 4, 6, 7};
  int          per;
  logic [3:0]  flags;
  for (int i = 0; i < 4; i++) begin
    per = 1 << (pos[i] + 1);
    flags[i] = (ticks_after(n - 1) / per) > (ticks_after(nc - 2) / per);
  end
  return flags;
endfunction

task automatic apb_write(timer_reg_e r, logic [31:0] data);
  @(posedge clk);
  #1;
  apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: {r, 2'b00}, pwdata: data};
  @(posedge clk);
  #1;
  apb_req.penable = 1'b1;
  ctrl_wr = (r == REG_CTRL) && data[0]; // Tells the cycle tracker about the commit edge.
  clr_wr  = (r == REG_IRQ_STAT);
  @(posedge clk);
  #1;
  apb_req = '0;
  ctrl_wr = 1'b0;
  clr_wr  = 1'b0;
endtask

task automatic apb_read(timer_reg_e r, output logic [31:0] data);
  @(posedge clk);
  #1;
  apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: {r, 2'b00}, pwdata: 32'h0};
  @(posedge clk);
  #1;
  apb_req.penable = 1'b1;
  @(negedge clk);
  data     = apb_rsp.prdata;
  sample_n = n_en;
  @(posedge clk);
  #1;
  apb_req = '0;
endtask

task automatic ss_read(logic [7:0] addr, output logic [31:0] data);
  @(posedge clk);
  #1;
  ss_in.addr = addr;
  @(negedge clk);
  data = ss_bus_out;
endtask

task automatic ss_write(logic [7:0] addr, logic [31:0] data);
  @(posedge clk);
  #1;
  ss_in.addr = addr;
  ss_in.data = data;
  ss_in.wren = 1'b1;
  @(posedge clk);
  #1;
  ss_in.wren = 1'b0;
endtask

`endif

/* tb/tb_system_timer.sv */
`timescale 1ns/10ps

module tb_system_timer;
  import ss_addresses::*;

  localparam int LIMIT = 40000;

  logic        clk;
  logic        reset_n;
  logic        clk_en;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        irq;
  timer_bits_t timer;
  ss_bus_t     ss_in;
  logic [31:0] ss_bus_out;

  integer seed = 32'haba2;
  int     n_en, cnt_base, rest_n, rest_base, clr_n, sample_n;
  int     errors, checks, tests, err_mark, cycle_count;
  logic   ctrl_wr, clr_wr;
  string  cur_test;
  event   check_ev;

  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];
  string       name_q[$];

  `include "tb_system_timer_ref.svh"

  system_timer_top #(.DIVIDER_WIDTH(3)) uut (
    .clk(clk), .reset_n(reset_n), .clk_en(clk_en),
    .apb_req(apb_req), .apb_rsp(apb_rsp), .irq(irq), .timer(timer),
    .ss_in(ss_in), .ss_bus_out(ss_bus_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Tracks enabled cycles since the last timer reset or restore.
  always @(posedge clk) begin
    if (!reset_n) begin
      n_en     = rest_n;
      cnt_base = rest_base;
    end else if (ctrl_wr) begin
      n_en     = 0;
      cnt_base = 0;
    end else if (clk_en) begin
      n_en++;
    end
    if (clr_wr) clr_n = n_en;
  end

  initial begin
    logic [31:0] g, e;
    string       s;
    forever begin
      @(check_ev);
      while (got_q.size() != 0) begin
        g = got_q.pop_front();
        e = exp_q.pop_front();
        s = name_q.pop_front();
        if (g !== e) begin
          $display("ERROR %0t: %s read %h, expected %h", $time, s, g, e);
          errors++;
        end
        checks++;
      end
    end
  end

  initial begin
    while (cycle_count < LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", LIMIT);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic queue_check(string label, logic [31:0] got, logic [31:0] exp);
    got_q.push_back(got);
    exp_q.push_back(exp);
    name_q.push_back(label);
    -> check_ev;
  endtask

  task automatic begin_test(string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    @(posedge clk);
    #1;
    tests++;
    $display("Test %s: done, %0d errors", cur_test, errors - err_mark);
  endtask

  task automatic run_random(int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1 clk_en = ($random(seed) % 4) != 0; // Enabled about three cycles in four.
    end
  endtask

  task automatic wait_enabled(int target);
    while (n_en < target) @(negedge clk);
  endtask

  initial begin
    logic [31:0] d, w_clk, w_sec;
    logic [23:0] v;
    logic [23:0] sec_exp;
    clk_en = 1'b0;
    reset_n = 1'b0;
    apb_req = '0;
    ss_in = '0;
    ctrl_wr = 1'b0;
    clr_wr = 1'b0;
    {n_en, cnt_base, rest_n, rest_base, clr_n, sample_n} = '0;
    {errors, checks, tests, cycle_count} = '0;
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;
    ss_in.reset_n = 1'b1;

    begin_test("reset values");
    apb_read(REG_TIMER, d);
    queue_check("TIMER", d, 32'h0);
    apb_read(REG_SECONDS, d);
    queue_check("SECONDS", d, 32'h0);
    apb_read(REG_IRQ_STAT, d);
    queue_check("IRQ_STAT", d, 32'h0);
    queue_check("irq", irq, 32'h0);
    queue_check("pready", apb_rsp.pready, 32'h1);
    queue_check("tick256", timer.tick256, 32'h0);
    end_test();

    begin_test("random enable counting");
    for (int i = 0; i < 50; i++) begin
      run_random(40 + ($random(seed) & 63));
      apb_read(REG_TIMER, d);
      queue_check("TIMER", d, timer_ref(cnt_base, sample_n));
      if (i % 10 == 9) begin
        clk_en = 1'b0; // Disabled stretch, value must hold.
        repeat (10) @(posedge clk);
        apb_read(REG_TIMER, d);
        queue_check("TIMER held", d, timer_ref(cnt_base, sample_n));
      end
    end
    end_test();

    begin_test("timer reset");
    clk_en = 1'b1;
    apb_write(REG_CTRL, 32'h1);
    repeat (18) begin
      @(negedge clk);
      queue_check("counter_256", timer[7:0], timer_ref(0, n_en));
      queue_check("tick256", timer.tick256, ticks_after(n_en) != ticks_after(n_en - 1));
      if (n_en == 9) queue_check("first tick", timer[7:0], 32'h1);
    end
    run_random(100);
    apb_read(REG_TIMER, d);
    queue_check("TIMER", d, timer_ref(cnt_base, sample_n));
    end_test();

    begin_test("interrupts");
    clk_en = 1'b1;
    apb_write(REG_IRQ_EN, 32'hc); // 2 Hz and 1 Hz only.
    apb_write(REG_CTRL, 32'h1);
    apb_write(REG_IRQ_STAT, 32'hf);
    wait_enabled(80);
    apb_read(REG_IRQ_STAT, d);
    queue_check("IRQ_STAT fast", d, flags_ref(sample_n, clr_n));
    queue_check("irq masked", irq, 32'h0);
    wait_enabled(2070);
    apb_read(REG_IRQ_STAT, d);
    queue_check("IRQ_STAT all", d, flags_ref(sample_n, clr_n));
    queue_check("irq raised", irq, 32'h1);
    apb_write(REG_IRQ_STAT, 32'hf);
    repeat (2) @(posedge clk);
    @(negedge clk);
    queue_check("irq cleared", irq, 32'h0);
    apb_read(REG_IRQ_STAT, d);
    queue_check("IRQ_STAT cleared", d, flags_ref(sample_n, clr_n));
    end_test();

    begin_test("seconds load");
    clk_en = 1'b1;
    v = 24'($random(seed));
    apb_write(REG_CTRL, 32'h1);
    apb_write(REG_SECONDS, {8'h0, v});
    apb_read(REG_SECONDS, d);
    queue_check("SECONDS loaded", d, seconds_ref(v, sample_n));
    wait_enabled(2070);
    apb_read(REG_SECONDS, d);
    queue_check("SECONDS after 256 ticks", d, 24'(v + 1));
    queue_check("SECONDS ref", d, seconds_ref(v, sample_n));
    end_test();

    begin_test("savestate");
    clk_en = 1'b0;
    if (n_en % 8 == 0) begin
      rest_base = timer_ref(cnt_base, n_en); // Restored divider of 0 skips the next wrap.
      rest_n    = 0;
    end else begin
      rest_base = cnt_base;
      rest_n    = n_en;
    end
    sec_exp = seconds_ref(v, n_en);
    ss_read(SS_CLOCK, w_clk);
    ss_read(SS_SECONDS, w_sec);
    ss_write(SS_CLOCK, w_clk);
    ss_write(SS_SECONDS, w_sec);
    reset_n = 1'b0;
    clk_en = 1'b1;
    repeat (3) @(posedge clk);
    #1 reset_n = 1'b1;
    clk_en = 1'b0;
    apb_read(REG_TIMER, d);
    queue_check("TIMER restored", d, timer_ref(cnt_base, sample_n));
    apb_read(REG_SECONDS, d);
    queue_check("SECONDS restored", d, {8'h0, sec_exp});
    run_random(150);
    apb_read(REG_TIMER, d);
    queue_check("TIMER after restore", d, timer_ref(cnt_base, sample_n));
    end_test();

    #1;
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* verilog/bus_connector.sv */
`timescale 1ns/10ps

module bus_connector #(
  parameter logic [7:0]  ADDRESS       = 8'h00,
  parameter logic [31:0] DEFAULT_VALUE = 32'h0
) (
  input  logic                  clk,

  input  ss_addresses::ss_bus_t ss_in,
  output logic [31:0]           bus_out,

  input  logic [31:0]           current_data,
  output logic [31:0]           new_data
);

  logic        addr_hit;
  logic [31:0] stored_data;

  assign addr_hit = ss_in.addr == ADDRESS;

  // Slot register, holds the word that the owner restores from during reset.
  always_ff @(posedge clk) begin
    if (!ss_in.reset_n) begin
      stored_data <= DEFAULT_VALUE;
    end else if (ss_in.wren && addr_hit) begin
      stored_data <= ss_in.data;
    end
  end

  assign new_data = stored_data;

  // Read side returns the live state, not the stored word.
  assign bus_out = addr_hit ? current_data : 32'h0;

endmodule

/* verilog/clock.sv */
`timescale 1ns/10ps

module clock #(
  parameter int DIVIDER_WIDTH = 7
) (
  input  logic                      clk,
  input  logic                      clk_en,
  input  logic                      reset_n,

  input  logic                      reset_clock_timer,

  output ss_addresses::timer_bits_t timer,

  input  ss_addresses::ss_bus_t     ss_in,
  output logic [31:0]               ss_out
);
  import ss_addresses::*;

  localparam int SS_BITS = DIVIDER_WIDTH + 9;

  logic                     prev_reset;
  logic                     timer_256_tick;
  logic [DIVIDER_WIDTH-1:0] divider;
  logic [7:0]               counter_256;

  logic [31:0] ss_current_data;
  logic [31:0] ss_new_data;

  assign ss_current_data = 32'({timer_256_tick, divider, counter_256});

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      // Restore from the slot. A saved divider of 0 counts as a fresh timer reset.
      prev_reset <= ss_new_data[DIVIDER_WIDTH+7:8] == '0;
      {timer_256_tick, divider, counter_256} <= ss_new_data[SS_BITS-1:0];
    end else if (reset_clock_timer) begin
      prev_reset     <= 1'b1;
      divider        <= '0;
      counter_256    <= 8'h0;
      timer_256_tick <= 1'b0;
    end else if (clk_en) begin
      prev_reset     <= 1'b0;
      timer_256_tick <= 1'b0;
      divider        <= divider + 1'b1;

      // First wrap after a timer reset does not tick.
      if (divider == '0 && !prev_reset) begin
        counter_256    <= counter_256 + 8'h1;
        timer_256_tick <= 1'b1;
      end
    end
  end

  assign timer.tick256 = timer_256_tick;
  assign timer.hz128   = counter_256[0];
  assign timer.hz64    = counter_256[1];
  assign timer.hz32    = counter_256[2];
  assign timer.hz16    = counter_256[3];
  assign timer.hz8     = counter_256[4];
  assign timer.hz4     = counter_256[5];
  assign timer.hz2     = counter_256[6];
  assign timer.hz1     = counter_256[7];

  bus_connector #(
    .ADDRESS      (SS_CLOCK),
    .DEFAULT_VALUE(32'h0)
  ) ss (
    .clk         (clk),
    .ss_in       (ss_in),
    .bus_out     (ss_out),
    .current_data(ss_current_data),
    .new_data    (ss_new_data)
  );

endmodule

/* verilog/seconds_counter.sv */
`timescale 1ns/10ps

module seconds_counter (
  input  logic                  clk,
  input  logic                  clk_en,
  input  logic                  reset_n,

  input  logic                  hz1,

  input  logic                  sec_load,
  input  logic [23:0]           sec_value,
  output logic [23:0]           seconds,

  input  ss_addresses::ss_bus_t ss_in,
  output logic [31:0]           ss_out
);
  import ss_addresses::*;

  logic        prev_hz1;
  logic        hz1_fall;

  logic [31:0] ss_current_data;
  logic [31:0] ss_new_data;

  // Bit 24 keeps the edge detector in step with the restored clock.
  assign ss_current_data = {7'h0, prev_hz1, seconds};

  // A full second has passed when the 1 Hz bit drops.
  assign hz1_fall = prev_hz1 && !hz1;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      prev_hz1 <= ss_new_data[24];
      seconds  <= ss_new_data[23:0];
    end else begin
      if (clk_en) begin
        prev_hz1 <= hz1;
      end

      if (sec_load) begin
        seconds <= sec_value; // Load wins over a same-cycle increment.
      end else if (clk_en && hz1_fall) begin
        seconds <= seconds + 24'h1; // Wraps at 2^24.
      end
    end
  end

  bus_connector #(
    .ADDRESS      (SS_SECONDS),
    .DEFAULT_VALUE(32'h0)
  ) ss (
    .clk         (clk),
    .ss_in       (ss_in),
    .bus_out     (ss_out),
    .current_data(ss_current_data),
    .new_data    (ss_new_data)
  );

endmodule

/* verilog/ss_addresses.sv */
package ss_addresses;

  // Savestate slot addresses.
  localparam logic [7:0] SS_CLOCK   = 8'h00;
  localparam logic [7:0] SS_SECONDS = 8'h01;
  localparam logic [7:0] SS_IRQ     = 8'h02;

  typedef struct packed {
    logic [31:0] data;
    logic [7:0]  addr;
    logic        wren;
    logic        reset_n; // Loads every slot with its default while low.
  } ss_bus_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apb_rsp_t;

  // Word offsets, paddr[7:2].
  typedef enum logic [5:0] {
    REG_CTRL     = 6'd0,
    REG_TIMER    = 6'd1,
    REG_SECONDS  = 6'd2,
    REG_IRQ_EN   = 6'd3,
    REG_IRQ_STAT = 6'd4
  } timer_reg_e;

  // Field order puts hz128 in bit 0, so bits 7:0 read as counter_256.
  typedef struct packed {
    logic tick256;
    logic hz1, hz2, hz4, hz8, hz16, hz32, hz64, hz128;
  } timer_bits_t;

endpackage

/* verilog/system_timer_top.sv */
`timescale 1ns/10ps

module system_timer_top #(
  parameter int DIVIDER_WIDTH = 7
) (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      clk_en,

  input  ss_addresses::apb_req_t    apb_req,
  output ss_addresses::apb_rsp_t    apb_rsp,
  output logic                      irq,
  output ss_addresses::timer_bits_t timer,

  input  ss_addresses::ss_bus_t     ss_in,
  output logic [31:0]               ss_bus_out
);

  logic        reset_clock_timer;
  logic        sec_load;
  logic [23:0] sec_value;
  logic [23:0] seconds;
  logic [3:0]  irq_en;
  logic [3:0]  irq_clear;
  logic [3:0]  irq_stat;

  logic [31:0] clock_ss_out;
  logic [31:0] seconds_ss_out;
  logic [31:0] irq_ss_out;

  clock #(
    .DIVIDER_WIDTH(DIVIDER_WIDTH)
  ) u_clock (
    .clk              (clk),
    .clk_en           (clk_en),
    .reset_n          (reset_n),
    .reset_clock_timer(reset_clock_timer),
    .timer            (timer),
    .ss_in            (ss_in),
    .ss_out           (clock_ss_out)
  );

  seconds_counter u_seconds (
    .clk      (clk),
    .clk_en   (clk_en),
    .reset_n  (reset_n),
    .hz1      (timer.hz1),
    .sec_load (sec_load),
    .sec_value(sec_value),
    .seconds  (seconds),
    .ss_in    (ss_in),
    .ss_out   (seconds_ss_out)
  );

  timer_irq u_irq (
    .clk      (clk),
    .clk_en   (clk_en),
    .reset_n  (reset_n),
    .timer    (timer),
    .irq_en   (irq_en),
    .irq_clear(irq_clear),
    .irq_stat (irq_stat),
    .irq      (irq),
    .ss_in    (ss_in),
    .ss_out   (irq_ss_out)
  );

  timer_apb_regs u_regs (
    .clk              (clk),
    .reset_n          (reset_n),
    .apb_req          (apb_req),
    .apb_rsp          (apb_rsp),
    .timer            (timer),
    .seconds          (seconds),
    .irq_stat         (irq_stat),
    .reset_clock_timer(reset_clock_timer),
    .sec_load         (sec_load),
    .sec_value        (sec_value),
    .irq_en           (irq_en),
    .irq_clear        (irq_clear)
  );

  // Only the addressed slot drives nonzero data.
  assign ss_bus_out = clock_ss_out | seconds_ss_out | irq_ss_out;

endmodule

/* verilog/timer_apb_regs.sv */
`timescale 1ns/10ps

module timer_apb_regs (
  input  logic                      clk,
  input  logic                      reset_n,

  input  ss_addresses::apb_req_t    apb_req,
  output ss_addresses::apb_rsp_t    apb_rsp,

  input  ss_addresses::timer_bits_t timer,
  input  logic [23:0]               seconds,
  input  logic [3:0]                irq_stat,

  output logic                      reset_clock_timer,
  output logic                      sec_load,
  output logic [23:0]               sec_value,
  output logic [3:0]                irq_en,
  output logic [3:0]                irq_clear
);
  import ss_addresses::*;

  timer_reg_e  reg_sel;
  logic        access;
  logic        wr_access;
  logic        rd_phase;
  logic [7:0]  counter_256;
  logic [31:0] rd_data;

  assign reg_sel = timer_reg_e'(apb_req.paddr[7:2]);

  // Access phase is psel with penable. No wait states.
  assign access    = apb_req.psel && apb_req.penable;
  assign wr_access = access && apb_req.pwrite;
  assign rd_phase  = apb_req.psel && !apb_req.pwrite;

  assign counter_256 = {timer.hz1, timer.hz2, timer.hz4, timer.hz8,
                        timer.hz16, timer.hz32, timer.hz64, timer.hz128};

  // Pulses are high only in the access cycle, so targets commit at its edge.
  assign reset_clock_timer = wr_access && reg_sel == REG_CTRL && apb_req.pwdata[0];
  assign sec_load          = wr_access && reg_sel == REG_SECONDS;
  assign sec_value         = apb_req.pwdata[23:0];

  always_comb begin
    irq_clear = 4'h0;
    if (wr_access && reg_sel == REG_IRQ_STAT) begin
      irq_clear = apb_req.pwdata[3:0]; // Write one to clear.
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      irq_en <= 4'h0;
    end else if (wr_access && reg_sel == REG_IRQ_EN) begin
      irq_en <= apb_req.pwdata[3:0];
    end
  end

  // Read mux shows live values.
  always_comb begin
    rd_data = 32'h0;
    case (reg_sel)
      REG_CTRL: begin
        rd_data = 32'h0;
      end
      REG_TIMER: begin
        rd_data = {24'h0, counter_256};
      end
      REG_SECONDS: begin
        rd_data = {8'h0, seconds};
      end
      REG_IRQ_EN: begin
        rd_data = {28'h0, irq_en};
      end
      REG_IRQ_STAT: begin
        rd_data = {28'h0, irq_stat};
      end
      default: begin
        rd_data = 32'h0;
      end
    endcase
  end

  assign apb_rsp.prdata = rd_phase ? rd_data : 32'h0;
  assign apb_rsp.pready = 1'b1;

endmodule

/* verilog/timer_irq.sv */
`timescale 1ns/10ps

module timer_irq (
  input  logic                      clk,
  input  logic                      clk_en,
  input  logic                      reset_n,

  input  ss_addresses::timer_bits_t timer,

  input  logic [3:0]                irq_en,
  input  logic [3:0]                irq_clear,
  output logic [3:0]                irq_stat,
  output logic                      irq,

  input  ss_addresses::ss_bus_t     ss_in,
  output logic [31:0]               ss_out
);
  import ss_addresses::*;

  logic [3:0]  sel_bits;
  logic [3:0]  prev_bits;
  logic [3:0]  falls;

  logic [31:0] ss_current_data;
  logic [31:0] ss_new_data;

  // Flag 0 is 32 Hz, then 8 Hz, 2 Hz, 1 Hz.
  assign sel_bits = {timer.hz1, timer.hz2, timer.hz8, timer.hz32};

  assign falls = clk_en ? (prev_bits & ~sel_bits) : 4'h0;

  assign ss_current_data = {24'h0, prev_bits, irq_stat};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      prev_bits <= ss_new_data[7:4];
      irq_stat  <= ss_new_data[3:0];
      irq       <= 1'b0;
    end else begin
      if (clk_en) begin
        prev_bits <= sel_bits;
      end
      irq_stat <= (irq_stat & ~irq_clear) | falls; // New edge beats a clear.
      irq      <= |(irq_stat & irq_en);
    end
  end

  bus_connector #(
    .ADDRESS      (SS_IRQ),
    .DEFAULT_VALUE(32'h0)
  ) ss (
    .clk         (clk),
    .ss_in       (ss_in),
    .bus_out     (ss_out),
    .current_data(ss_current_data),
    .new_data    (ss_new_data)
  );

endmodule
